/* design/rvv_pkg.sv */
// Shared types and constants for the vector dispatch front end
// Lane count, queue sizing, encodings and the instruction/command words
package rvv_pkg;

  // Dispatch width and command queue sizing
  localparam int NUM_LANES = 2;
  localparam int QUEUE_DEPTH = 8;
  localparam int NUM_READS = 2 * NUM_LANES;

  // Free space is reported up to two dispatch groups
  localparam int CAP_MAX = 2 * NUM_LANES;
  localparam int CAP_BITS = $clog2(CAP_MAX + 1);

  // Count of lanes within one dispatch group
  localparam int LANE_CNT_BITS = $clog2(NUM_LANES + 1);

  // Queue pointer and occupancy widths
  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  // funct3 value shared by vsetvli, vsetivli and vsetvl
  localparam logic [2:0] FUNCT3_OPCFG = 3'b111;

  // Instruction class as seen by the vector unit
  typedef enum logic [1:0] {
    OP_RVV   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } rvv_opcode_e;

  // vsew encoding
  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2
  } rvv_sew_e;

  // vlmul encoding, fractional values at the top of the range
  typedef enum logic [2:0] {
    LMUL1  = 3'd0,
    LMUL2  = 3'd1,
    LMUL4  = 3'd2,
    LMUL8  = 3'd3,
    LMULF8 = 3'd5,
    LMULF4 = 3'd6,
    LMULF2 = 3'd7
  } rvv_lmul_e;

  // Instruction bits 31:7 follow the opcode class
  typedef struct packed {
    rvv_opcode_e opcode;
    logic [24:0] bits;
  } rvv_inst_t;

  // Architectural vector configuration
  typedef struct packed {
    logic [31:0] vl;
    rvv_sew_e    sew;
    rvv_lmul_e   lmul;
    logic        ta;
    logic        ma;
  } rvv_config_t;

  // Command handed to the vector backend
  typedef struct packed {
    rvv_opcode_e opcode;
    logic [24:0] bits;
    logic [31:0] rs1;
    rvv_config_t arch_state;
  } rvv_cmd_t;

  // Configuration after reset
  localparam rvv_config_t RESET_CONFIG = '{
    vl:   32'd16,
    sew:  SEW8,
    lmul: LMUL1,
    ta:   1'b0,
    ma:   1'b0
  };

endpackage

/* design/rvv_scalar_regfile.sv */
// Scalar register file, 32 x 32 bits with x0 tied to zero
// Two registered reads and one writeback port per dispatch lane
module rvv_scalar_regfile
  import rvv_pkg::*;
(
  input  logic                            clk,
  input  logic                            rstn,
  input  logic [NUM_READS-1:0][4:0]       rd_idx,
  output logic [NUM_READS-1:0][31:0]      rd_data,
  input  logic [NUM_LANES-1:0]            wr_valid,
  input  logic [NUM_LANES-1:0][4:0]       wr_addr,
  input  logic [NUM_LANES-1:0][31:0]      wr_data
);

  // x1..x31 only, x0 has no storage
  logic [31:0] regs [31:1];

  // Writeback, later lanes overwrite earlier ones on the same address
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int r = 1; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        // Writes to x0 are dropped
        if (wr_valid[i] && (wr_addr[i] != 5'd0)) begin
          regs[wr_addr[i]] <= wr_data[i];
        end
      end
    end
  end

  // Registered reads see the value from before this cycle's writeback
  always_ff @(posedge clk) begin
    for (int j = 0; j < NUM_READS; j++) begin
      if (rd_idx[j] == 5'd0) begin
        rd_data[j] <= '0;
      end else begin
        rd_data[j] <= regs[rd_idx[j]];
      end
    end
  end

endmodule

/* design/rvv_front_end.sv */
// Vector dispatch front end
// Tracks vtype/vl, runs configuration instructions and builds commands
module rvv_front_end
  import rvv_pkg::*;
(
  input  logic                            clk,
  input  logic                            rstn,

  // Dispatch from the scalar core
  input  logic [NUM_LANES-1:0]            inst_valid,
  input  rvv_inst_t [NUM_LANES-1:0]       inst_data,
  output logic [NUM_LANES-1:0]            inst_ready,

  // Scalar operand reads, data arrives with the stage
  output logic [NUM_READS-1:0][4:0]       rd_idx,
  input  logic [NUM_READS-1:0][31:0]      reg_read_data,

  // New vl written back to rd
  output logic [NUM_LANES-1:0]            reg_write_valid,
  output logic [NUM_LANES-1:0][4:0]       reg_write_addr,
  output logic [NUM_LANES-1:0][31:0]      reg_write_data,

  // Unaligned commands towards the aligner
  output logic [NUM_LANES-1:0]            ucmd_valid,
  output rvv_cmd_t [NUM_LANES-1:0]        ucmd_data,

  // Free queue entries
  input  logic [CAP_BITS-1:0]             queue_capacity
);

  // Current configuration
  rvv_config_t config_state;

  // Stage holding last cycle's accepted instructions
  logic [NUM_LANES-1:0] stage_valid;
  rvv_inst_t            stage_inst [NUM_LANES];

  // Back-pressure
  logic [LANE_CNT_BITS-1:0] in_psum [NUM_LANES+1];
  logic [LANE_CNT_BITS-1:0] stage_cnt;
  logic [CAP_BITS-1:0]      avail;

  always_comb begin
    in_psum[0] = '0;
    stage_cnt = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      in_psum[i+1] = in_psum[i] + LANE_CNT_BITS'(inst_valid[i]);
      stage_cnt = stage_cnt + LANE_CNT_BITS'(stage_valid[i]);
    end
    // Entries already promised to the stage are not free
    if (queue_capacity > CAP_BITS'(stage_cnt)) begin
      avail = queue_capacity - CAP_BITS'(stage_cnt);
    end else begin
      avail = '0;
    end
    // Lane i fits if fewer than avail valid lanes sit below it
    for (int i = 0; i < NUM_LANES; i++) begin
      inst_ready[i] = inst_valid[i] && (CAP_BITS'(in_psum[i]) < avail);
    end
  end

  // Operand indices go straight out, the register file supplies the delay
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rd_idx[2*i]   = inst_data[i].bits[12:8];
      rd_idx[2*i+1] = inst_data[i].bits[17:13];
    end
  end

  // Stage valids
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stage_valid <= '0;
    end else begin
      stage_valid <= inst_ready;
    end
  end

  // Stage payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      stage_inst[i] <= inst_data[i];
    end
  end

  // Configuration chained through the lanes in order
  rvv_config_t          cfg_chain [NUM_LANES+1];
  logic [NUM_LANES-1:0] is_cfg;
  logic [31:0]          rs1_val;
  logic [31:0]          rs2_val;

  always_comb begin
    cfg_chain[0] = config_state;
    for (int i = 0; i < NUM_LANES; i++) begin
      rs1_val = reg_read_data[2*i];
      rs2_val = reg_read_data[2*i+1];
      cfg_chain[i+1] = cfg_chain[i];
      is_cfg[i] = 1'b0;
      if (stage_valid[i] && (stage_inst[i].opcode == OP_RVV) &&
          (stage_inst[i].bits[7:5] == FUNCT3_OPCFG)) begin
        if (!stage_inst[i].bits[24]) begin
          // vsetvli, AVL from rs1 and vtype from the immediate
          cfg_chain[i+1].vl   = rs1_val;
          cfg_chain[i+1].lmul = rvv_lmul_e'(stage_inst[i].bits[15:13]);
          cfg_chain[i+1].sew  = rvv_sew_e'(stage_inst[i].bits[18:16]);
          cfg_chain[i+1].ta   = stage_inst[i].bits[19];
          cfg_chain[i+1].ma   = stage_inst[i].bits[20];
          is_cfg[i] = 1'b1;
        end else if (stage_inst[i].bits[24:23] == 2'b11) begin
          // vsetivli, AVL is the uimm in the rs1 slot
          cfg_chain[i+1].vl   = 32'(stage_inst[i].bits[12:8]);
          cfg_chain[i+1].lmul = rvv_lmul_e'(stage_inst[i].bits[15:13]);
          cfg_chain[i+1].sew  = rvv_sew_e'(stage_inst[i].bits[18:16]);
          cfg_chain[i+1].ta   = stage_inst[i].bits[19];
          cfg_chain[i+1].ma   = stage_inst[i].bits[20];
          is_cfg[i] = 1'b1;
        end else if (stage_inst[i].bits[24:23] == 2'b10) begin
          // vsetvl, vtype packed in rs2
          cfg_chain[i+1].vl   = rs1_val;
          cfg_chain[i+1].lmul = rvv_lmul_e'(rs2_val[2:0]);
          cfg_chain[i+1].sew  = rvv_sew_e'(rs2_val[5:3]);
          cfg_chain[i+1].ta   = rs2_val[6];
          cfg_chain[i+1].ma   = rs2_val[7];
          is_cfg[i] = 1'b1;
        end
      end
    end
  end

  // Last lane's result becomes the state for the next group
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      config_state <= RESET_CONFIG;
    end else begin
      config_state <= cfg_chain[NUM_LANES];
    end
  end

  // Commands and vl writeback
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      ucmd_valid[i] = stage_valid[i] && !is_cfg[i];
      ucmd_data[i].opcode = stage_inst[i].opcode;
      ucmd_data[i].bits = stage_inst[i].bits;
      // funct3[2] marks a scalar operand (OPIVX, OPFVF, OPMVX)
      ucmd_data[i].rs1 = stage_inst[i].bits[7] ? reg_read_data[2*i] : 32'd0;
      // State in force before this lane
      ucmd_data[i].arch_state = cfg_chain[i];
      reg_write_valid[i] = is_cfg[i];
      reg_write_addr[i] = stage_inst[i].bits[4:0];
      reg_write_data[i] = cfg_chain[i+1].vl;
    end
  end

endmodule

/* design/rvv_cmd_aligner.sv */
// Command aligner, packs valid lanes into the lowest outputs
// Purely combinational and order preserving
module rvv_cmd_aligner
  import rvv_pkg::*;
(
  input  logic [NUM_LANES-1:0]            valid_in,
  input  rvv_cmd_t [NUM_LANES-1:0]        data_in,
  output logic [NUM_LANES-1:0]            valid_out,
  output rvv_cmd_t [NUM_LANES-1:0]        data_out
);

  // Target slot of each input, number of valid lanes below it
  logic [LANE_CNT_BITS-1:0] slot [NUM_LANES+1];

  always_comb begin
    slot[0] = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      slot[i+1] = slot[i] + LANE_CNT_BITS'(valid_in[i]);
    end
  end

  // One mux per output lane, picks the input whose slot matches
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      valid_out[k] = 1'b0;
      data_out[k] = '0;
      for (int i = 0; i < NUM_LANES; i++) begin
        if (valid_in[i] && (slot[i] == LANE_CNT_BITS'(k))) begin
          valid_out[k] = 1'b1;
          data_out[k] = data_in[i];
        end
      end
    end
  end

endmodule

/* design/rvv_cmd_queue.sv */
// Command queue, multi-lane write and single-entry read
// Reports free space to the front end for back-pressure
module rvv_cmd_queue
  import rvv_pkg::*;
(
  input  logic                            clk,
  input  logic                            rstn,

  // Aligned writes, valid lanes form a prefix
  input  logic [NUM_LANES-1:0]            wr_valid,
  input  rvv_cmd_t [NUM_LANES-1:0]        wr_data,
  output logic [CAP_BITS-1:0]             capacity,

  // Head of queue
  output logic                            cmd_valid,
  output rvv_cmd_t                        cmd_data,
  input  logic                            cmd_ready
);

  rvv_cmd_t mem [QUEUE_DEPTH];

  logic [PTR_BITS-1:0]      head;
  logic [PTR_BITS-1:0]      tail;
  logic [CNT_BITS-1:0]      count;
  logic [LANE_CNT_BITS-1:0] wr_cnt;
  logic [CNT_BITS-1:0]      free_cnt;
  logic                     pop;

  // Number of lanes written this cycle
  always_comb begin
    wr_cnt = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      wr_cnt = wr_cnt + LANE_CNT_BITS'(wr_valid[i]);
    end
  end

  assign pop = cmd_valid && cmd_ready;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      tail <= tail + PTR_BITS'(wr_cnt);
      if (pop) begin
        head <= head + PTR_BITS'(1);
      end
      count <= count + CNT_BITS'(wr_cnt) - CNT_BITS'(pop);
    end
  end

  // Storage, lane i goes to tail + i
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wr_valid[i]) begin
        mem[tail + PTR_BITS'(i)] <= wr_data[i];
      end
    end
  end

  // Head read straight from storage
  assign cmd_valid = (count != '0);
  assign cmd_data = mem[head];

  // Free entries, clipped to what the front end can use
  assign free_cnt = CNT_BITS'(QUEUE_DEPTH) - count;
  assign capacity = (free_cnt > CNT_BITS'(CAP_MAX)) ? CAP_BITS'(CAP_MAX)
                                                    : CAP_BITS'(free_cnt);

endmodule

/* design/rvv_core_top.sv */
// Vector dispatch top level
// Register file, front end, aligner and command queue
module rvv_core_top
  import rvv_pkg::*;
(
  input  logic                            clk,
  input  logic                            rstn,

  // Dispatch
  input  logic [NUM_LANES-1:0]            inst_valid,
  input  rvv_inst_t [NUM_LANES-1:0]       inst_data,
  output logic [NUM_LANES-1:0]            inst_ready,

  // Command output, one per cycle
  output logic                            cmd_valid,
  input  logic                            cmd_ready,
  output rvv_opcode_e                     cmd_opcode,
  output logic [24:0]                     cmd_bits,
  output logic [31:0]                     cmd_rs1,
  output logic [31:0]                     cmd_vl,
  output rvv_sew_e                        cmd_sew,
  output rvv_lmul_e                       cmd_lmul,
  output logic                            cmd_ta,
  output logic                            cmd_ma
);

  // Register file links
  logic [NUM_READS-1:0][4:0]  rd_idx;
  logic [NUM_READS-1:0][31:0] reg_read_data;
  logic [NUM_LANES-1:0]       reg_write_valid;
  logic [NUM_LANES-1:0][4:0]  reg_write_addr;
  logic [NUM_LANES-1:0][31:0] reg_write_data;

  // Command path
  logic [NUM_LANES-1:0]       ucmd_valid;
  rvv_cmd_t [NUM_LANES-1:0]   ucmd_data;
  logic [NUM_LANES-1:0]       acmd_valid;
  rvv_cmd_t [NUM_LANES-1:0]   acmd_data;
  logic [CAP_BITS-1:0]        queue_capacity;
  rvv_cmd_t                   cmd_data;

  rvv_scalar_regfile i_regfile (
    .clk      (clk),
    .rstn     (rstn),
    .rd_idx   (rd_idx),
    .rd_data  (reg_read_data),
    .wr_valid (reg_write_valid),
    .wr_addr  (reg_write_addr),
    .wr_data  (reg_write_data)
  );

  rvv_front_end i_front_end (
    .clk             (clk),
    .rstn            (rstn),
    .inst_valid      (inst_valid),
    .inst_data       (inst_data),
    .inst_ready      (inst_ready),
    .rd_idx          (rd_idx),
    .reg_read_data   (reg_read_data),
    .reg_write_valid (reg_write_valid),
    .reg_write_addr  (reg_write_addr),
    .reg_write_data  (reg_write_data),
    .ucmd_valid      (ucmd_valid),
    .ucmd_data       (ucmd_data),
    .queue_capacity  (queue_capacity)
  );

  rvv_cmd_aligner i_aligner (
    .valid_in  (ucmd_valid),
    .data_in   (ucmd_data),
    .valid_out (acmd_valid),
    .data_out  (acmd_data)
  );

  rvv_cmd_queue i_queue (
    .clk       (clk),
    .rstn      (rstn),
    .wr_valid  (acmd_valid),
    .wr_data   (acmd_data),
    .capacity  (queue_capacity),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready)
  );

  // Head command split into loose fields
  assign cmd_opcode = cmd_data.opcode;
  assign cmd_bits   = cmd_data.bits;
  assign cmd_rs1    = cmd_data.rs1;
  assign cmd_vl     = cmd_data.arch_state.vl;
  assign cmd_sew    = cmd_data.arch_state.sew;
  assign cmd_lmul   = cmd_data.arch_state.lmul;
  assign cmd_ta     = cmd_data.arch_state.ta;
  assign cmd_ma     = cmd_data.arch_state.ma;

endmodule

/* sim/rvv_core_checker.sv */
// Protocol assertions for the vector dispatch top level
// Dispatch handshake, reset behavior and head stability under back-pressure
module rvv_core_checker
  import rvv_pkg::*;
(
  input logic                 clk,
  input logic                 rstn,
  input logic [NUM_LANES-1:0] inst_valid,
  input logic [NUM_LANES-1:0] inst_ready,
  input logic                 cmd_valid,
  input logic                 cmd_ready,
  input rvv_opcode_e          cmd_opcode,
  input logic [24:0]          cmd_bits,
  input logic [31:0]          cmd_rs1,
  input logic [31:0]          cmd_vl,
  input rvv_sew_e             cmd_sew,
  input rvv_lmul_e            cmd_lmul,
  input logic                 cmd_ta,
  input logic                 cmd_ma
);

  // Whole head command as one word
  logic [98:0] head_word;

  assign head_word = {cmd_opcode, cmd_bits, cmd_rs1, cmd_vl, cmd_sew, cmd_lmul, cmd_ta, cmd_ma};

  // A lane is never ready without a valid instruction
  a_ready_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
    (inst_ready & ~inst_valid) == '0)
    else $error("inst_ready high on a lane without inst_valid");

  // Any valid lane below a ready lane is ready too
  for (genvar i = 1; i < NUM_LANES; i++) begin : g_prefix
    a_ready_prefix: assert property (@(posedge clk) disable iff (!rstn)
      inst_ready[i] |-> ((inst_valid[i-1:0] & ~inst_ready[i-1:0]) == '0))
      else $error("ready lanes are not a prefix of the valid lanes");
  end

  // Queue is empty while reset is held
  a_idle_in_reset: assert property (@(posedge clk) !rstn |-> !cmd_valid)
    else $error("cmd_valid high during reset");

  // Stalled head keeps its contents
  a_head_stable: assert property (@(posedge clk) disable iff (!rstn)
    (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(head_word)))
    else $error("head command changed while stalled");

endmodule

bind rvv_core_top rvv_core_checker i_checker (.*);

/* sim/tb_rvv_core.sv */
// Testbench for the vector dispatch top level
// Directed tests checked against a reference model of the vtype/vl rules
module tb_rvv_core
  import rvv_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  // Dispatch groups of the five tests with the fill loop at its limit
  localparam int TOTAL_OPS = 1 + 2 + 6 + 4 + 3 * QUEUE_DEPTH;
  // Each group gets 40 cycles and each drain 200
  localparam int WATCHDOG_CYCLES = 16 + TOTAL_OPS * 40 + 5 * 200;
  // Configuration instruction kinds
  localparam int VSETVLI = 0;
  localparam int VSETIVLI = 1;
  localparam int VSETVL = 2;

  logic                      clk;
  logic                      rstn;
  logic [NUM_LANES-1:0]      inst_valid;
  rvv_inst_t [NUM_LANES-1:0] inst_data;
  logic [NUM_LANES-1:0]      inst_ready;
  logic                      cmd_valid;
  logic                      cmd_ready;
  rvv_opcode_e               cmd_opcode;
  logic [24:0]               cmd_bits;
  logic [31:0]               cmd_rs1;
  logic [31:0]               cmd_vl;
  rvv_sew_e                  cmd_sew;
  rvv_lmul_e                 cmd_lmul;
  logic                      cmd_ta;
  logic                      cmd_ma;

  // Reference model of the configuration, the x registers and the commands still owed
  rvv_config_t m_cfg;
  logic [31:0] regs [32];
  rvv_cmd_t    exp_q [$];

  logic [31:0]          lfsr;
  // Lanes offered but not yet accepted
  logic [NUM_LANES-1:0] pend;
  // Consumer mode 0 keeps cmd_ready high, 1 holds it low and 2 draws it at random
  int                   ready_mode;
  int                   fill_cnt;
  int                   errors;
  int                   checks;
  int                   test_errors;
  string                cur_test;

  rvv_core_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  // vsetvli and vsetivli take vtype in arg while vsetvl takes the rs2 index
  function automatic rvv_inst_t cfg_inst(input int kind, input logic [4:0] rd,
                                         input logic [4:0] src, input logic [7:0] arg);
    rvv_inst_t inst;
    inst.opcode = OP_RVV;
    if (kind == VSETVLI) begin
      inst.bits = {4'b0000, arg, src, 3'b111, rd};
    end else if (kind == VSETIVLI) begin
      inst.bits = {4'b1100, arg, src, 3'b111, rd};
    end else begin
      inst.bits = {7'b1000000, arg[4:0], src, 3'b111, rd};
    end
    return inst;
  endfunction

  // Unmasked OPIVV/OPIVX style vector op with funct6 zero
  function automatic rvv_inst_t arith_inst(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
    rvv_inst_t inst;
    inst.opcode = OP_RVV;
    inst.bits = {6'b000000, 1'b1, rs2, rs1, f3, rd};
    return inst;
  endfunction

  function automatic rvv_inst_t rand_inst();
    rvv_inst_t  inst;
    logic [1:0] op;
    op = 2'(rand_bits(2));
    if (op == 2'd3) begin
      op = 2'd0;
    end
    inst.opcode = rvv_opcode_e'(op);
    inst.bits = 25'(rand_bits(25));
    // funct3 111 on a vector op would turn it into vset*
    if (inst.opcode == OP_RVV && inst.bits[7:5] == 3'b111) begin
      inst.bits[7:5] = 3'b000;
    end
    return inst;
  endfunction

  // Apply one accepted instruction to the model in dispatch order
  task automatic model_accept(input rvv_inst_t inst);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [7:0]  vt;
    rvv_cmd_t    c;
    rd = inst.bits[4:0];
    a = regs[inst.bits[12:8]];
    b = regs[inst.bits[17:13]];
    if (inst.opcode == OP_RVV && inst.bits[7:5] == 3'b111) begin
      // vsetvli layout by default
      vt = inst.bits[20:13];
      m_cfg.vl = a;
      if (inst.bits[24:23] == 2'b11) begin
        m_cfg.vl = 32'(inst.bits[12:8]);
      end else if (inst.bits[24]) begin
        vt = b[7:0];
      end
      m_cfg.lmul = rvv_lmul_e'(vt[2:0]);
      m_cfg.sew = rvv_sew_e'(vt[5:3]);
      m_cfg.ta = vt[6];
      m_cfg.ma = vt[7];
      if (rd != 5'd0) begin
        regs[rd] = m_cfg.vl;
      end
    end else begin
      c.opcode = inst.opcode;
      c.bits = inst.bits;
      c.rs1 = inst.bits[7] ? a : 32'd0;
      c.arch_state = m_cfg;
      exp_q.push_back(c);
    end
  endtask

  task automatic compare_field(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", cur_test, field, exp, act);
      errors++;
    end
  endtask

  // Head is taken on the next edge and compared here
  always @(negedge clk) begin : head_compare
    rvv_cmd_t e;
    if (rstn && cmd_valid && cmd_ready) begin
      if (exp_q.size() == 0) begin
        $display("%s: DUT gave a command nobody dispatched, bits %h", cur_test, cmd_bits);
        errors++;
      end else begin
        e = exp_q.pop_front();
        compare_field("opcode", 32'(e.opcode), 32'(cmd_opcode));
        compare_field("bits", 32'(e.bits), 32'(cmd_bits));
        compare_field("rs1", e.rs1, cmd_rs1);
        compare_field("vl", e.arch_state.vl, cmd_vl);
        compare_field("sew", 32'(e.arch_state.sew), 32'(cmd_sew));
        compare_field("lmul", 32'(e.arch_state.lmul), 32'(cmd_lmul));
        compare_field("ta", 32'(e.arch_state.ta), 32'(cmd_ta));
        compare_field("ma", 32'(e.arch_state.ma), 32'(cmd_ma));
      end
    end
  end

  // Consumer side
  always @(posedge clk) begin
    if (ready_mode == 0) begin
      cmd_ready <= 1'b1;
    end else if (ready_mode == 1) begin
      cmd_ready <= 1'b0;
    end else begin
      cmd_ready <= rand_bit();
    end
  end

  task automatic offer(input logic [NUM_LANES-1:0] mask, input rvv_inst_t i0,
                       input rvv_inst_t i1);
    @(posedge clk);
    inst_data[0] <= i0;
    inst_data[1] <= i1;
    inst_valid <= mask;
    pend = mask;
  endtask

  // Record the lanes taken on the coming edge and keep holding the rest
  task automatic take_accepted();
    @(negedge clk);
    for (int i = 0; i < NUM_LANES; i++) begin
      if (pend[i] && inst_ready[i]) begin
        model_accept(inst_data[i]);
        fill_cnt++;
      end
    end
    pend = pend & ~inst_ready;
    @(posedge clk);
    inst_valid <= pend;
  endtask

  // Offer one group and hold it until every lane is taken
  task automatic issue(input logic [NUM_LANES-1:0] mask, input rvv_inst_t i0,
                       input rvv_inst_t i1);
    int waited;
    waited = 0;
    offer(mask, i0, i1);
    while (pend != '0 && waited < 200) begin
      take_accepted();
      waited++;
    end
    if (pend != '0) begin
      $display("%s: dispatch stalled with lanes %b never accepted", cur_test, pend);
      errors++;
      pend = '0;
      inst_valid <= '0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    // Let the stage and queue settle before looking
    repeat (3) @(negedge clk);
    while ((exp_q.size() != 0 || cmd_valid) && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= 200) begin
      $display("%s: %0d commands never came out of the queue", cur_test, exp_q.size());
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = errors;
  endtask

  task automatic report_test();
    $display("%s finished, %0d errors", cur_test, errors - test_errors);
  endtask

  // Reset vtype, vl 16 and a scalar operand of zero
  task automatic reset_config_test();
    start_test("reset_config_test");
    issue(2'b11, arith_inst(3'b000, 5'd1, 5'd2, 5'd3), arith_inst(3'b100, 5'd4, 5'd5, 5'd6));
    wait_drain();
    report_test();
  endtask

  task automatic vsetivli_test();
    start_test("vsetivli_test");
    // vl 9 into x5 with ma1 SEW16 LMUL2
    issue(2'b01, cfg_inst(VSETIVLI, 5'd5, 5'd9, {1'b1, 1'b0, SEW16, LMUL2}), '0);
    issue(2'b01, arith_inst(3'b100, 5'd3, 5'd5, 5'd4), '0);
    wait_drain();
    report_test();
  endtask

  task automatic vsetvl_test();
    start_test("vsetvl_test");
    // AVLs go to x6 and x10 and vtype SEW16 LMUL4 to x7
    issue(2'b11, cfg_inst(VSETIVLI, 5'd6, 5'd20, 8'h00), cfg_inst(VSETIVLI, 5'd10, 5'd27, 8'h00));
    issue(2'b01, cfg_inst(VSETIVLI, 5'd7, 5'd10, 8'h00), '0);
    issue(2'b01, cfg_inst(VSETVLI, 5'd8, 5'd6, {1'b0, 1'b1, SEW32, LMUL8}), '0);
    issue(2'b01, arith_inst(3'b100, 5'd1, 5'd8, 5'd2), '0);
    issue(2'b01, cfg_inst(VSETVL, 5'd9, 5'd10, 8'd7), '0);
    issue(2'b01, arith_inst(3'b100, 5'd2, 5'd9, 5'd3), '0);
    wait_drain();
    report_test();
  endtask

  task automatic lane_order_test();
    start_test("lane_order_test");
    // Lane 0 config feeds the lane 1 command
    // funct3 000 drops the nonzero x5 operand
    issue(2'b11, cfg_inst(VSETIVLI, 5'd11, 5'd3, {1'b0, 1'b1, SEW8, LMUL1}),
          arith_inst(3'b000, 5'd4, 5'd5, 5'd2));
    // Lane 1 config comes after the lane 0 command
    issue(2'b11, arith_inst(3'b100, 5'd5, 5'd9, 5'd3),
          cfg_inst(VSETIVLI, 5'd12, 5'd7, {1'b1, 1'b0, SEW32, LMUL2}));
    // Lone lane 1 ends up in queue lane 0
    issue(2'b10, '0, arith_inst(3'b100, 5'd6, 5'd12, 5'd1));
    issue(2'b11, arith_inst(3'b000, 5'd7, 5'd0, 5'd1), arith_inst(3'b100, 5'd8, 5'd11, 5'd2));
    wait_drain();
    report_test();
  endtask

  task automatic backpressure_test();
    logic [NUM_LANES-1:0] mask;
    rvv_inst_t            i0;
    rvv_inst_t            i1;
    int                   groups;
    int                   waited;
    start_test("backpressure_test");
    ready_mode = 1;
    fill_cnt = 0;
    groups = 0;
    // Fill with a stalled consumer until a lane is declined
    while (pend == '0 && groups < 3 * QUEUE_DEPTH) begin
      mask = NUM_LANES'(rand_bits(NUM_LANES));
      if (mask == '0) begin
        mask = 1;
      end
      i0 = rand_inst();
      i1 = rand_inst();
      offer(mask, i0, i1);
      take_accepted();
      groups++;
    end
    if (pend == '0) begin
      $display("%s: inst_ready never dropped while cmd_ready was low", cur_test);
      errors++;
    end
    checks++;
    if (fill_cnt > QUEUE_DEPTH) begin
      $display("[ERROR] %s: accepted without a pop expected at most %0d actual %0d",
               cur_test, QUEUE_DEPTH, fill_cnt);
      errors++;
    end
    // Random pops while the declined lanes are held
    ready_mode = 2;
    waited = 0;
    while (pend != '0 && waited < 200) begin
      take_accepted();
      waited++;
    end
    if (pend != '0) begin
      $display("%s: held lanes never accepted after the queue drained", cur_test);
      errors++;
    end
    wait_drain();
    ready_mode = 0;
    report_test();
  endtask

  initial begin
    rstn = 1'b0;
    inst_valid = '0;
    inst_data = '0;
    cmd_ready = 1'b0;
    pend = '0;
    ready_mode = 0;
    fill_cnt = 0;
    errors = 0;
    checks = 0;
    lfsr = 32'hc818;
    m_cfg = '{vl: 32'd16, sew: SEW8, lmul: LMUL1, ta: 1'b0, ma: 1'b0};
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    reset_config_test();
    vsetivli_test();
    vsetvl_test();
    lane_order_test();
    backpressure_test();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* files.f */
design/rvv_pkg.sv
design/rvv_scalar_regfile.sv
design/rvv_front_end.sv
design/rvv_cmd_aligner.sv
design/rvv_cmd_queue.sv
design/rvv_core_top.sv
sim/rvv_core_checker.sv
sim/tb_rvv_core.sv

/* Makefile */
SIM := obj_dir/Vtb_rvv_core

.PHONY: all run clean

all: run

$(SIM): files.f $(wildcard design/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module tb_rvv_core -f files.f -o Vtb_rvv_core

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
